//--- sources.f
hw/cpu_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/reg_result.sv
hw/cpu_core.sv
dv/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert -f sources.f --top-module tb_cpu_core -o tb_cpu_core \
	&& ./obj_dir/tb_cpu_core | grep "Everything OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- dv/tb_cpu_core.sv
module tb_cpu_core
	import cpu_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int RAND_CYCLES = 400;
	// Four legal words, the illegal one, eight ignored strobes, four idle
	localparam int FINAL_CYCLES = 17;
	localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_REGS + RAND_CYCLES + FINAL_CYCLES;

	logic clk;
	logic reset;
	logic w_ir;
	word_t ir_in;
	reg_sel_t rsel;
	word_t w;
	logic [0:3] flags;
	logic stop;

	logic [31:0] rnd_state;

	// Reference state, numeric words with bit 15 as the sign
	logic [15:0] m_regs [0:NUM_REGS-1];
	logic [0:3] m_flags;
	logic m_stop;
	// Slots for decode, execute and commit
	logic pipe_valid [0:2];
	logic [15:0] pipe_word [0:2];

	cpu_core DUT (
		.__clk(clk),
		.reset(reset),
		.w_ir(w_ir),
		.ir_in(ir_in),
		.rsel(rsel),
		.w(w),
		.flags(flags),
		.stop(stop)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#((TOTAL_CYCLES + 20) * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in time");
		$display("Something failed");
		$fatal(1);
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------

	function automatic logic [31:0] advance_xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Legal opcode with fields from the upper random bits, extra weight on LWT
	function automatic logic [15:0] legal_word(input logic [31:0] r);
		logic [3:0] opc;
		opc = (r[31:30] == 2'b00) ? OPC_LWT : 4'(r % 32'd12);
		return {opc, r[27:16]};
	endfunction

	function automatic logic [15:0] illegal_word(input logic [31:0] r);
		return {2'b11, r[1:0], r[27:16]};
	endfunction

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("error %0t: %s: got %h, expected %h", $time, what, actual, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// Apply one committed instruction to the reference state
	task automatic apply_instr(input logic [15:0] word);
		logic [3:0] opc;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [16:0] t;
		logic c;
		logic v;
		logic wr_reg;
		logic wr_flags;
		opc = word[15:12];
		ra = word[8:6];
		rb = (opc == OPC_CW) ? word[2:0] : word[5:3];
		a = m_regs[ra];
		b = m_regs[rb];
		r = a;
		c = 1'b0;
		v = 1'b0;
		wr_reg = 1'b1;
		wr_flags = 1'b1;
		case (opc)
			OPC_AW, OPC_AC: begin
				t = {1'b0, a} + {1'b0, b} + {16'b0, (opc == OPC_AC) && m_flags[FLAG_C]};
				r = t[15:0];
				c = t[16];
				v = (a[15] == b[15]) && (r[15] != a[15]);
			end
			OPC_SW, OPC_CW: begin
				t = {1'b0, a} - {1'b0, b};
				r = t[15:0];
				// Borrow out
				c = t[16];
				v = (a[15] != b[15]) && (r[15] != a[15]);
				wr_reg = (opc == OPC_SW);
			end
			OPC_NR: r = a & b;
			OPC_OR: r = a | b;
			OPC_XR: r = a ^ b;
			OPC_ER: r = a & ~b;
			OPC_LWT: begin
				r = {{10{word[5]}}, word[5:0]};
				wr_flags = 1'b0;
			end
			OPC_SLZ: begin
				r = {a[14:0], 1'b0};
				c = a[15];
			end
			OPC_SHR: begin
				r = {a[15], a[15:1]};
				c = a[0];
			end
			default: begin
				// No-op and illegal codes
				wr_reg = 1'b0;
				wr_flags = 1'b0;
			end
		endcase
		if (wr_reg) begin
			m_regs[ra] = r;
		end
		if (wr_flags) begin
			m_flags[FLAG_Z] = (r == 16'h0000);
			m_flags[FLAG_M] = r[15];
			m_flags[FLAG_V] = v;
			m_flags[FLAG_C] = c;
		end
	endtask

	// Drive one cycle on the falling edge, follow the rising edge in the model, check
	task automatic run_cycle(input logic fire, input logic [15:0] word, input logic [2:0] sel);
		logic illegal_in_dec;
		logic accepted;
		w_ir = fire;
		ir_in = word;
		rsel = sel;
		@(negedge clk);
		illegal_in_dec = pipe_valid[0] && (pipe_word[0][15:12] > OPC_SHR);
		accepted = fire && !m_stop && !illegal_in_dec;
		if (illegal_in_dec) begin
			m_stop = 1'b1;
		end
		pipe_valid[2] = pipe_valid[1];
		pipe_word[2] = pipe_word[1];
		pipe_valid[1] = pipe_valid[0];
		pipe_word[1] = pipe_word[0];
		pipe_valid[0] = accepted;
		pipe_word[0] = word;
		if (pipe_valid[2]) begin
			apply_instr(pipe_word[2]);
		end
		check_value(w, m_regs[sel], $sformatf("w for register %0d", sel));
		check_value({12'b0, flags}, {12'b0, m_flags}, "flags");
		check_value({15'b0, stop}, {15'b0, m_stop}, "stop");
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		w_ir = 1'b0;
		ir_in = '0;
		rsel = '0;
		rnd_state = 32'd80320;
		m_flags = '0;
		m_stop = 1'b0;
		for (int i = 0; i < NUM_REGS; i++) begin
			m_regs[i] = 16'h0000;
		end
		for (int i = 0; i < 3; i++) begin
			pipe_valid[i] = 1'b0;
			pipe_word[i] = 16'h0000;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		// Panel readout of every register after reset
		for (int i = 0; i < NUM_REGS; i++) begin
			run_cycle(1'b0, 16'h0000, 3'(i));
		end

		// Random legal stream, often back to back
		repeat (RAND_CYCLES) begin
			rnd_state = advance_xorshift(rnd_state);
			run_cycle(rnd_state[29:28] != 2'b00, legal_word(rnd_state), rnd_state[2:0]);
		end

		// Illegal opcode behind a few legal ones
		repeat (4) begin
			rnd_state = advance_xorshift(rnd_state);
			run_cycle(1'b1, legal_word(rnd_state), rnd_state[2:0]);
		end
		rnd_state = advance_xorshift(rnd_state);
		run_cycle(1'b1, illegal_word(rnd_state), rnd_state[2:0]);
		// These strobes must be ignored
		repeat (8) begin
			rnd_state = advance_xorshift(rnd_state);
			run_cycle(1'b1, legal_word(rnd_state), rnd_state[2:0]);
		end
		repeat (4) begin
			rnd_state = advance_xorshift(rnd_state);
			run_cycle(1'b0, 16'h0000, rnd_state[2:0]);
		end
		check_value({15'b0, stop}, 16'd1, "stop after illegal opcode");

		$display("Everything OK");
		$finish;
	end

endmodule

//--- hw/cpu_core.sv
module cpu_core
	import cpu_pkg::*;
#(
	parameter bit STOP_ON_ILLEGAL = 1'b1
) (
	input logic __clk,
	input logic reset,

	// from control panel
	input logic w_ir,
	input word_t ir_in,
	input reg_sel_t rsel,

	// to control panel
	output word_t w,
	output logic [0:3] flags,
	output logic stop
);

// -----------------------------------------------------------------------
// --- Decode ------------------------------------------------------------
// -----------------------------------------------------------------------

	logic dec_valid;
	alu_op_t dec_op;
	reg_sel_t dec_a;
	reg_sel_t dec_b;
	word_t dec_short;

	instr_decode #(.STOP_ON_ILLEGAL(STOP_ON_ILLEGAL)) decode (
		.__clk(__clk),
		.reset(reset),
		.w_ir(w_ir),
		.ir_in(ir_in),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_a(dec_a),
		.dec_b(dec_b),
		.dec_short(dec_short),
		.stop(stop)
	);

// -----------------------------------------------------------------------
// --- Execute -----------------------------------------------------------
// -----------------------------------------------------------------------

	reg_sel_t rd_a_sel;
	reg_sel_t rd_b_sel;
	word_t rd_a_data;
	word_t rd_b_data;
	logic [0:3] cur_flags;
	logic ex_valid;
	reg_sel_t ex_dest;
	word_t ex_data;
	logic ex_wr_reg;
	logic ex_wr_flags;
	logic [0:3] ex_flags;

	alu_execute execute (
		.__clk(__clk),
		.reset(reset),
		.dec_valid(dec_valid),
		.dec_op(dec_op),
		.dec_a(dec_a),
		.dec_b(dec_b),
		.dec_short(dec_short),
		.rd_a_sel(rd_a_sel),
		.rd_b_sel(rd_b_sel),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.cur_flags(cur_flags),
		.ex_valid(ex_valid),
		.ex_dest(ex_dest),
		.ex_data(ex_data),
		.ex_wr_reg(ex_wr_reg),
		.ex_wr_flags(ex_wr_flags),
		.ex_flags(ex_flags)
	);

// -----------------------------------------------------------------------
// --- Result ------------------------------------------------------------
// -----------------------------------------------------------------------

	reg_result result (
		.__clk(__clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_dest(ex_dest),
		.ex_data(ex_data),
		.ex_wr_reg(ex_wr_reg),
		.ex_wr_flags(ex_wr_flags),
		.ex_flags(ex_flags),
		.rd_a_sel(rd_a_sel),
		.rd_b_sel(rd_b_sel),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.cur_flags(cur_flags),
		.rsel(rsel),
		.w(w),
		.flags(flags)
	);

endmodule

//--- hw/reg_result.sv
module reg_result
	import cpu_pkg::*;
(
	input logic __clk,
	input logic reset,

	// from execute register
	input logic ex_valid,
	input reg_sel_t ex_dest,
	input word_t ex_data,
	input logic ex_wr_reg,
	input logic ex_wr_flags,
	input logic [0:3] ex_flags,

	// read ports for execute
	input reg_sel_t rd_a_sel,
	input reg_sel_t rd_b_sel,
	output word_t rd_a_data,
	output word_t rd_b_data,
	output logic [0:3] cur_flags,

	// control panel view
	input reg_sel_t rsel,
	output word_t w,
	output logic [0:3] flags
);

	word_t regs [0:NUM_REGS-1];
	logic [0:3] flags_q;

	// ----------------------------------------------------------------------
	// General registers and flags
	// ----------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			flags_q <= '0;
		end else begin
			if (ex_valid && ex_wr_reg) begin
				regs[ex_dest] <= ex_data;
			end
			if (ex_valid && ex_wr_flags) begin
				flags_q <= ex_flags;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Read ports
	// ----------------------------------------------------------------------

	assign rd_a_data = regs[rd_a_sel];
	assign rd_b_data = regs[rd_b_sel];
	assign cur_flags = flags_q;

	// Panel shows the selected register and the committed flags
	assign w = regs[rsel];
	assign flags = flags_q;

	// Execute stage offers no write while reset is held
	a_no_write_in_reset: assert property (@(posedge __clk)
		reset && $past(reset) |-> !(ex_valid && (ex_wr_reg || ex_wr_flags)));

endmodule

//--- hw/alu_execute.sv
module alu_execute
	import cpu_pkg::*;
(
	input logic __clk,
	input logic reset,

	// from decode
	input logic dec_valid,
	input alu_op_t dec_op,
	input reg_sel_t dec_a,
	input reg_sel_t dec_b,
	input word_t dec_short,

	// register file read ports and committed flags
	output reg_sel_t rd_a_sel,
	output reg_sel_t rd_b_sel,
	input word_t rd_a_data,
	input word_t rd_b_data,
	input logic [0:3] cur_flags,

	// to result stage
	output logic ex_valid,
	output reg_sel_t ex_dest,
	output word_t ex_data,
	output logic ex_wr_reg,
	output logic ex_wr_flags,
	output logic [0:3] ex_flags
);

	word_t a_val;
	word_t b_val;
	logic carry_in;
	logic [0:WORD_W] add_res;
	logic [0:WORD_W] sub_res;
	word_t result;
	logic c_out;
	logic v_out;
	logic [0:3] flags_next;
	logic wr_reg;
	logic wr_flags;

	// ----------------------------------------------------------------------
	// Operand fetch
	// ----------------------------------------------------------------------

	assign rd_a_sel = dec_a;
	assign rd_b_sel = dec_b;

	// Result still in the execute register wins over the register file
	always_comb begin
		a_val = rd_a_data;
		b_val = rd_b_data;
		if (ex_valid && ex_wr_reg && (ex_dest == dec_a)) begin
			a_val = ex_data;
		end
		if (ex_valid && ex_wr_reg && (ex_dest == dec_b)) begin
			b_val = ex_data;
		end
	end

	// Carry for AC, newest flags first
	assign carry_in = (dec_op == op_ac)
		&& ((ex_valid && ex_wr_flags) ? ex_flags[FLAG_C] : cur_flags[FLAG_C]);

	// ----------------------------------------------------------------------
	// ALU
	// ----------------------------------------------------------------------

	assign add_res = {1'b0, a_val} + {1'b0, b_val} + {{WORD_W{1'b0}}, carry_in};
	// Top bit is the borrow
	assign sub_res = {1'b0, a_val} - {1'b0, b_val};

	always_comb begin
		result = a_val;
		c_out = 1'b0;
		v_out = 1'b0;
		case (dec_op)
			op_aw, op_ac: begin
				result = add_res[1:WORD_W];
				c_out = add_res[0];
				v_out = (a_val[0] == b_val[0]) && (add_res[1] != a_val[0]);
			end
			op_sw, op_cw: begin
				result = sub_res[1:WORD_W];
				c_out = sub_res[0];
				v_out = (a_val[0] != b_val[0]) && (sub_res[1] != a_val[0]);
			end
			op_nr: result = a_val & b_val;
			op_or: result = a_val | b_val;
			op_xr: result = a_val ^ b_val;
			op_er: result = a_val & ~b_val;
			op_lwt: result = dec_short;
			op_slz: begin
				result = {a_val[1:WORD_W-1], 1'b0};
				c_out = a_val[0];
			end
			op_shr: begin
				result = {a_val[0], a_val[0:WORD_W-2]};
				c_out = a_val[WORD_W-1];
			end
			default: result = a_val;
		endcase
	end

	always_comb begin
		flags_next = '0;
		flags_next[FLAG_Z] = (result == '0);
		flags_next[FLAG_M] = result[0];
		flags_next[FLAG_V] = v_out;
		flags_next[FLAG_C] = c_out;
	end

	assign wr_reg = dec_valid && (dec_op != op_nop) && (dec_op != op_cw);
	assign wr_flags = dec_valid && (dec_op != op_nop) && (dec_op != op_lwt);

	// ----------------------------------------------------------------------
	// Execute register
	// ----------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_wr_reg <= 1'b0;
			ex_wr_flags <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
			ex_wr_reg <= wr_reg;
			ex_wr_flags <= wr_flags;
		end
	end

	always_ff @(posedge __clk) begin
		if (dec_valid) begin
			ex_dest <= dec_a;
			ex_data <= result;
			ex_flags <= flags_next;
		end
	end

	a_wr_needs_valid: assert property (@(posedge __clk) disable iff (reset)
		(ex_wr_reg || ex_wr_flags) |-> ex_valid);

endmodule

//--- hw/instr_decode.sv
module instr_decode
	import cpu_pkg::*;
#(
	parameter bit STOP_ON_ILLEGAL = 1'b1
) (
	input logic __clk,
	input logic reset,

	// from control panel
	input logic w_ir,
	input word_t ir_in,

	// to execute
	output logic dec_valid,
	output alu_op_t dec_op,
	output reg_sel_t dec_a,
	output reg_sel_t dec_b,
	output word_t dec_short,

	output logic stop
);

	localparam int SHORT_W = FLD_S_LSB - FLD_S_MSB + 1;

	word_t ir;
	logic [0:3] opc;
	logic illegal;
	logic halt_now;
	logic accept;

	// ----------------------------------------------------------------------
	// Instruction register
	// ----------------------------------------------------------------------

	// Halt pending from an illegal word already blocks the next strobe
	assign halt_now = dec_valid & illegal & STOP_ON_ILLEGAL;
	assign accept = w_ir & ~stop & ~halt_now;

	always_ff @(posedge __clk) begin
		if (accept) begin
			ir <= ir_in;
		end
	end

	always_ff @(posedge __clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			stop <= 1'b0;
		end else begin
			dec_valid <= accept;
			if (halt_now) begin
				stop <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Opcode translation
	// ----------------------------------------------------------------------

	assign opc = ir[OPC_MSB:OPC_LSB];

	always_comb begin
		dec_op = op_nop;
		illegal = 1'b0;
		case (opc)
			OPC_NOP: dec_op = op_nop;
			OPC_AW: dec_op = op_aw;
			OPC_AC: dec_op = op_ac;
			OPC_SW: dec_op = op_sw;
			OPC_NR: dec_op = op_nr;
			OPC_OR: dec_op = op_or;
			OPC_XR: dec_op = op_xr;
			OPC_ER: dec_op = op_er;
			OPC_LWT: dec_op = op_lwt;
			OPC_CW: dec_op = op_cw;
			OPC_SLZ: dec_op = op_slz;
			OPC_SHR: dec_op = op_shr;
			default: begin
				// Codes 12..15, run as a no-op when not halting
				dec_op = op_nop;
				illegal = 1'b1;
			end
		endcase
	end

	assign dec_a = ir[FLD_A_MSB:FLD_A_LSB];

	// Compare takes its second operand from C
	assign dec_b = (dec_op == op_cw) ? ir[FLD_C_MSB:FLD_C_LSB] : ir[FLD_B_MSB:FLD_B_LSB];

	assign dec_short = {{(WORD_W - SHORT_W){ir[FLD_S_MSB]}}, ir[FLD_S_MSB:FLD_S_LSB]};

	// Stop comes from a strobed illegal word two edges back
	a_stop_cause: assert property (@(posedge __clk) disable iff (reset)
		$rose(stop) |-> $past(w_ir, 2) && ($past(ir_in[OPC_MSB:OPC_LSB], 2) > OPC_SHR));

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

	// ----------------------------------------------------------------------
	// Machine word and register numbers
	// ----------------------------------------------------------------------

	localparam int WORD_W = 16;
	localparam int NUM_REGS = 8;

	// Bit 0 is the most significant bit
	typedef logic [0:WORD_W-1] word_t;
	typedef logic [0:2] reg_sel_t;

	typedef enum logic [0:3] {
		op_nop,
		op_aw,
		op_ac,
		op_sw,
		op_nr,
		op_or,
		op_xr,
		op_er,
		op_lwt,
		op_cw,
		op_slz,
		op_shr
	} alu_op_t;

	// ----------------------------------------------------------------------
	// Opcode field, bits 0..3 of the instruction word
	// ----------------------------------------------------------------------

	localparam int OPC_MSB = 0;
	localparam int OPC_LSB = 3;

	localparam logic [0:3] OPC_NOP = 4'd0;
	localparam logic [0:3] OPC_AW  = 4'd1;
	localparam logic [0:3] OPC_AC  = 4'd2;
	localparam logic [0:3] OPC_SW  = 4'd3;
	localparam logic [0:3] OPC_NR  = 4'd4;
	localparam logic [0:3] OPC_OR  = 4'd5;
	localparam logic [0:3] OPC_XR  = 4'd6;
	localparam logic [0:3] OPC_ER  = 4'd7;
	localparam logic [0:3] OPC_LWT = 4'd8;
	localparam logic [0:3] OPC_CW  = 4'd9;
	localparam logic [0:3] OPC_SLZ = 4'd10;
	localparam logic [0:3] OPC_SHR = 4'd11;

	// Register fields and the short argument
	localparam int FLD_A_MSB = 7;
	localparam int FLD_A_LSB = 9;
	localparam int FLD_B_MSB = 10;
	localparam int FLD_B_LSB = 12;
	localparam int FLD_C_MSB = 13;
	localparam int FLD_C_LSB = 15;
	localparam int FLD_S_MSB = 10;
	localparam int FLD_S_LSB = 15;

	// Positions in the 4-bit flag vector
	localparam int FLAG_Z = 0;
	localparam int FLAG_M = 1;
	localparam int FLAG_V = 2;
	localparam int FLAG_C = 3;

endpackage
